//--- project.f
source/dcache_pkg.sv
source/dcache_storage.sv
source/dcache_lookup.sv
source/dcache_replace.sv
source/dcache_ctrl.sv
source/dcache_mem_port.sv
source/dcache_top.sv
tests/tb_mem_model.sv
tests/tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_dcache
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache;

    localparam int CLK_PERIOD  = 10;
    localparam int READY_LIMIT = 100;   // cycles per request

    typedef struct {
        string             name;
        logic              is_wr;
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t wdata;
        dcache_pkg::strb_t wstrb;
        dcache_pkg::word_t exp_rdata;
        int                exp_rd;
        int                exp_wr;
        dcache_pkg::addr_t exp_waddr;   // only looked at when a write-back is expected
    } test_t;

    logic              clk;
    logic              rstn;
    dcache_pkg::addr_t addr;
    dcache_pkg::word_t wdata;
    dcache_pkg::strb_t wstrb;
    logic              rvalid, wvalid, rready, wready;
    dcache_pkg::word_t rdata;
    logic              mem_rvalid, mem_rready, mem_rlast;
    dcache_pkg::addr_t mem_raddr, mem_waddr, last_waddr;
    dcache_pkg::word_t mem_rdata, mem_wdata;
    logic              mem_wvalid, mem_wready, mem_wlast, mem_bready, mem_bvalid;
    int                rd_bursts, wr_bursts;
    test_t             tests [$];
    int                errors, passed, failed;
    logic              table_ready;

    dcache_top dut_i (.*);

    tb_mem_model mem_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // expected values
    //////////////////////////////
    function automatic dcache_pkg::word_t pattern(input dcache_pkg::addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic dcache_pkg::word_t merge_word(input dcache_pkg::word_t old_w,
                                                    input dcache_pkg::word_t new_w,
                                                    input dcache_pkg::strb_t strb);
        dcache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic add_test(input string name, input logic is_wr, input dcache_pkg::addr_t a,
                            input dcache_pkg::word_t d, input dcache_pkg::strb_t s,
                            input dcache_pkg::word_t exp_d, input int rd, input int wr,
                            input dcache_pkg::addr_t wa);
        tests.push_back('{name, is_wr, a, d, s, exp_d, rd, wr, wa});
    endtask

    // A, B and C all map to set 4
    task automatic build_table();
        add_test("cold_read_a", 0, 32'h40, '0, '0, pattern(32'h40), 1, 0, '0);
        add_test("hit_read_a", 0, 32'h44, '0, '0, pattern(32'h44), 0, 0, '0);
        add_test("write_hit_a", 1, 32'h48, 32'h11223344, 4'b0101, '0, 0, 0, '0);
        add_test("read_merged_a", 0, 32'h48, '0, '0,
                 merge_word(pattern(32'h48), 32'h11223344, 4'b0101), 0, 0, '0);
        add_test("write_alloc_b", 1, 32'h14c, 32'haabbccdd, 4'b1100, '0, 1, 0, '0);
        add_test("read_merged_b", 0, 32'h14c, '0, '0,
                 merge_word(pattern(32'h14c), 32'haabbccdd, 4'b1100), 0, 0, '0);
        add_test("touch_a", 0, 32'h40, '0, '0, pattern(32'h40), 0, 0, '0);
        add_test("evict_b_read_c", 0, 32'h240, '0, '0, pattern(32'h240), 1, 1, 32'h140);
        add_test("reread_b", 0, 32'h14c, '0, '0,
                 merge_word(pattern(32'h14c), 32'haabbccdd, 4'b1100), 1, 1, 32'h40);
        add_test("reread_a", 0, 32'h48, '0, '0,
                 merge_word(pattern(32'h48), 32'h11223344, 4'b0101), 1, 0, '0);
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_word(input string name, input dcache_pkg::word_t exp,
                              input dcache_pkg::word_t act);
        if (act !== exp) begin
            $display("Mismatch %s: rdata expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::addr_t exp,
                              input dcache_pkg::addr_t act);
        if (act !== exp) begin
            $display("Mismatch %s: write-back address expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        if (act != exp) begin
            $display("Mismatch %s: %s expected %0d, actual %0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic wait_ready(input logic is_wr, output logic seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < READY_LIMIT) begin
            @(negedge clk);
            seen = is_wr ? wready : rready;
            cycles++;
        end
    endtask

    task automatic run_test(input test_t t);
        int   rd_start;
        int   wr_start;
        int   err_start;
        logic seen;
        rd_start  = rd_bursts;
        wr_start  = wr_bursts;
        err_start = errors;
        @(negedge clk);
        addr   = t.addr;
        wdata  = t.wdata;
        wstrb  = t.is_wr ? t.wstrb : '0;
        rvalid = !t.is_wr;
        wvalid = t.is_wr;
        wait_ready(t.is_wr, seen);
        if (!seen) begin
            $display("%s: the cache gave no ready within %0d cycles", t.name, READY_LIMIT);
            errors++;
        end else if (!t.is_wr) begin
            check_word(t.name, t.exp_rdata, rdata);
        end
        rvalid = 1'b0;
        wvalid = 1'b0;
        check_count(t.name, "read bursts", t.exp_rd, rd_bursts - rd_start);
        check_count(t.name, "write bursts", t.exp_wr, wr_bursts - wr_start);
        if (t.exp_wr > 0)
            check_addr(t.name, t.exp_waddr, last_waddr);
        if (errors == err_start) begin
            $display("test %s passed", t.name);
            passed++;
        end else begin
            $display("test %s failed", t.name);
            failed++;
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        clk         = 1'b0;
        rstn        = 1'b0;
        addr        = '0;
        wdata       = '0;
        wstrb       = '0;
        rvalid      = 1'b0;
        wvalid      = 1'b0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        foreach (tests[i])
            run_test(tests[i]);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests.size(), passed, failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // whole-run limit scales with the table
    initial begin
        wait (table_ready);
        #(tests.size() * 200 * CLK_PERIOD);
        $display("watchdog expired before all %0d tests finished", tests.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- tests/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model (
    input  logic              clk,
    input  logic              rstn,
    input  logic              mem_rvalid,
    input  dcache_pkg::addr_t mem_raddr,
    output logic              mem_rready,
    output dcache_pkg::word_t mem_rdata,
    output logic              mem_rlast,
    input  logic              mem_wvalid,
    output logic              mem_wready,
    input  dcache_pkg::addr_t mem_waddr,
    input  dcache_pkg::word_t mem_wdata,
    input  logic              mem_wlast,
    input  logic              mem_bready,
    output logic              mem_bvalid,
    output int                rd_bursts,
    output int                wr_bursts,
    output dcache_pkg::addr_t last_waddr
);

    dcache_pkg::word_t words [1024];   // 4 KB window at address 0
    logic [1:0]        rd_beat;
    logic [1:0]        wr_beat;
    logic [1:0]        stall_cnt;

    // every word starts as its own byte address with a marker in the top half
    initial begin
        for (int i = 0; i < 1024; i++)
            words[i] = dcache_pkg::addr_t'(i * 4) ^ 32'h5a5a0000;
    end

    assign mem_rready = (stall_cnt != 2'd3);   // one stalled cycle in four
    assign mem_wready = (stall_cnt != 2'd1);
    assign mem_rdata  = words[{mem_raddr[11:4], rd_beat}];
    assign mem_rlast  = (rd_beat == 2'd3);

    always @(posedge clk) begin
        if (!rstn) begin
            stall_cnt  <= '0;
            rd_beat    <= '0;
            wr_beat    <= '0;
            mem_bvalid <= 1'b0;
            rd_bursts  <= 0;
            wr_bursts  <= 0;
            last_waddr <= '0;
        end else begin
            stall_cnt <= stall_cnt + 2'd1;
            if (mem_rvalid && mem_rready) begin
                rd_beat <= rd_beat + 2'd1;
                if (mem_rlast)
                    rd_bursts <= rd_bursts + 1;
            end
            if (mem_wvalid && mem_wready) begin
                words[{mem_waddr[11:4], wr_beat}] <= mem_wdata;
                wr_beat <= wr_beat + 2'd1;
                if (mem_wlast) begin
                    wr_bursts  <= wr_bursts + 1;
                    last_waddr <= mem_waddr;
                end
            end
            // write acknowledge one cycle after bready rises
            if (mem_bvalid && mem_bready)
                mem_bvalid <= 1'b0;
            else if (mem_bready)
                mem_bvalid <= 1'b1;
        end
    end

endmodule

//--- source/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic              clk,
    input  logic              rstn,
    // pipeline
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::word_t wdata,
    input  dcache_pkg::strb_t wstrb,
    input  logic              rvalid,
    input  logic              wvalid,
    output logic              rready,
    output logic              wready,
    output dcache_pkg::word_t rdata,
    // memory read
    output logic              mem_rvalid,
    output dcache_pkg::addr_t mem_raddr,
    input  logic              mem_rready,
    input  dcache_pkg::word_t mem_rdata,
    input  logic              mem_rlast,
    // memory write
    output logic              mem_wvalid,
    input  logic              mem_wready,
    output dcache_pkg::addr_t mem_waddr,
    output dcache_pkg::word_t mem_wdata,
    output logic              mem_wlast,
    output logic              mem_bready,
    input  logic              mem_bvalid
);

    dcache_pkg::cpu_req_t   cur_req;
    dcache_pkg::index_t     req_index, rd_index;
    dcache_pkg::line_t      rd_line0, rd_line1, ret_line, merge_line;
    dcache_pkg::tagv_t      rd_tagv0, rd_tagv1;
    dcache_pkg::line_strb_t hit_strb, wr_strb;
    dcache_pkg::way_t       hit_way, victim_way;
    logic hit, victim_dirty, req_load, wr_en, refill_sel, hit_update, refill_update;
    logic wb_start, wb_clear, data_from_ret, refill_done, wb_done;

    assign req_index = cur_req.addr[dcache_pkg::BYTE_OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
    assign rd_index  = req_load ? addr[dcache_pkg::BYTE_OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH]
                                : req_index;   // look ahead with the incoming address
    assign wr_strb   = !wr_en ? '0 : (refill_sel ? '1 : hit_strb);
    assign mem_raddr = {cur_req.addr[31:dcache_pkg::BYTE_OFFSET_WIDTH],
                        {dcache_pkg::BYTE_OFFSET_WIDTH{1'b0}}};

    dcache_storage storage_i (
        .clk, .rstn, .rd_index, .wr_index(req_index),
        .wr_way(refill_sel ? victim_way : hit_way), .wr_strb, .wr_line(merge_line),
        .wr_tag(cur_req.addr[31 -: dcache_pkg::TAG_WIDTH]), .tag_we(refill_sel),
        .rd_line0, .rd_line1, .rd_tagv0, .rd_tagv1);

    dcache_lookup lookup_i (
        .clk, .rstn, .addr, .wdata, .wstrb, .req_load, .data_from_ret,
        .rd_line0, .rd_line1, .rd_tagv0, .rd_tagv1, .ret_line,
        .cur_req, .hit, .hit_way, .rdata, .hit_strb, .merge_line);

    dcache_replace replace_i (
        .clk, .rstn, .index(req_index), .hit_way, .hit_update, .refill_update,
        .is_write(|cur_req.wstrb), .victim_way, .victim_dirty);

    dcache_ctrl ctrl_i (
        .clk, .rstn, .rvalid, .wvalid, .cur_req, .hit, .refill_done, .wb_done,
        .rready, .wready, .req_load, .wr_en, .refill_sel, .hit_update, .refill_update,
        .wb_start, .wb_clear, .data_from_ret, .mem_rvalid);

    dcache_mem_port mem_port_i (
        .clk, .rstn, .wb_start, .wb_clear, .victim_dirty,
        .victim_line(victim_way ? rd_line1 : rd_line0),
        .victim_tag(victim_way ? rd_tagv1.tag : rd_tagv0.tag), .index(req_index),
        .mem_rvalid, .mem_rready, .mem_rdata, .mem_rlast, .mem_wready, .mem_bvalid,
        .ret_line, .refill_done, .wb_done, .mem_wvalid, .mem_waddr, .mem_wdata,
        .mem_wlast, .mem_bready);

endmodule

//--- source/dcache_mem_port.sv
`timescale 1ns/1ns

module dcache_mem_port (
    input  logic               clk,
    input  logic               rstn,
    input  logic               wb_start,
    input  logic               wb_clear,
    input  logic               victim_dirty,
    input  dcache_pkg::line_t  victim_line,
    input  dcache_pkg::tag_t   victim_tag,
    input  dcache_pkg::index_t index,
    input  logic               mem_rvalid,
    input  logic               mem_rready,
    input  dcache_pkg::word_t  mem_rdata,
    input  logic               mem_rlast,
    input  logic               mem_wready,
    input  logic               mem_bvalid,
    output dcache_pkg::line_t  ret_line,
    output logic               refill_done,
    output logic               wb_done,
    output logic               mem_wvalid,
    output dcache_pkg::addr_t  mem_waddr,
    output dcache_pkg::word_t  mem_wdata,
    output logic               mem_wlast,
    output logic               mem_bready
);

    dcache_pkg::wb_state_t wb_state;
    dcache_pkg::wb_state_t wb_next;
    dcache_pkg::woff_t     beat_cnt;
    dcache_pkg::line_t     wb_line;
    dcache_pkg::addr_t     wb_addr;
    logic                  last_beat;

    //////////////////////////////
    // refill return buffer
    //////////////////////////////
    // lowest word arrives first and ends up at the bottom
    always_ff @(posedge clk) begin
        if (mem_rvalid && mem_rready)
            ret_line <= {mem_rdata, ret_line[dcache_pkg::LINE_BITS-1:32]};
    end

    assign refill_done = mem_rvalid && mem_rready && mem_rlast;

    //////////////////////////////
    // write-back buffer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wb_start) begin
            wb_line <= victim_line;
            wb_addr <= {victim_tag, index, {dcache_pkg::BYTE_OFFSET_WIDTH{1'b0}}};
        end else if (mem_wvalid && mem_wready) begin
            wb_line <= wb_line >> 32;
        end
    end

    assign last_beat = (beat_cnt == dcache_pkg::woff_t'(dcache_pkg::WORD_NUM - 1));

    // write-back state machine
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_state <= dcache_pkg::WB_IDLE;
            beat_cnt <= '0;
        end else begin
            wb_state <= wb_next;
            if (mem_wvalid && mem_wready)
                beat_cnt <= beat_cnt + dcache_pkg::woff_t'(1);   // wraps back to 0 after the last beat
        end
    end

    always_comb begin
        wb_next = wb_state;
        case (wb_state)
            dcache_pkg::WB_IDLE:
                if (wb_start)
                    wb_next = victim_dirty ? dcache_pkg::WB_DATA : dcache_pkg::WB_DONE;
            dcache_pkg::WB_DATA:
                if (mem_wready && last_beat)
                    wb_next = dcache_pkg::WB_RESP;
            dcache_pkg::WB_RESP:
                if (mem_bvalid)
                    wb_next = dcache_pkg::WB_DONE;
            dcache_pkg::WB_DONE:
                if (wb_clear)
                    wb_next = dcache_pkg::WB_IDLE;
            default: wb_next = dcache_pkg::WB_IDLE;
        endcase
    end

    assign mem_wvalid = (wb_state == dcache_pkg::WB_DATA);
    assign mem_wlast  = mem_wvalid && last_beat;
    assign mem_bready = (wb_state == dcache_pkg::WB_RESP);
    assign wb_done    = (wb_state == dcache_pkg::WB_DONE);
    assign mem_waddr  = wb_addr;
    assign mem_wdata  = wb_line[31:0];

endmodule

//--- source/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rvalid,
    input  logic                 wvalid,
    input  dcache_pkg::cpu_req_t cur_req,
    input  logic                 hit,
    input  logic                 refill_done,
    input  logic                 wb_done,
    output logic                 rready,
    output logic                 wready,
    output logic                 req_load,
    output logic                 wr_en,
    output logic                 refill_sel,
    output logic                 hit_update,
    output logic                 refill_update,
    output logic                 wb_start,
    output logic                 wb_clear,
    output logic                 data_from_ret,
    output logic                 mem_rvalid
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t next_state;
    logic                    is_write;

    assign is_write = |cur_req.wstrb;

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= dcache_pkg::IDLE;
        else
            state <= next_state;
    end

    //////////////////////////////
    // next state and outputs
    //////////////////////////////
    always_comb begin
        next_state    = state;
        rready        = 1'b0;
        wready        = 1'b0;
        req_load      = 1'b0;
        wr_en         = 1'b0;
        refill_sel    = 1'b0;
        hit_update    = 1'b0;
        refill_update = 1'b0;
        wb_start      = 1'b0;
        wb_clear      = 1'b0;
        data_from_ret = 1'b0;
        mem_rvalid    = 1'b0;
        case (state)
            dcache_pkg::IDLE: begin
                if (rvalid || wvalid) begin
                    req_load   = 1'b1;
                    next_state = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    wr_en      = is_write;          // masked bytes only
                    hit_update = 1'b1;
                    rready     = !is_write;
                    wready     = is_write;
                    next_state = dcache_pkg::IDLE;
                end else begin
                    wb_start   = 1'b1;              // victim is latched now
                    next_state = dcache_pkg::MISS;
                end
            end
            dcache_pkg::MISS: begin
                mem_rvalid = 1'b1;
                if (refill_done)
                    next_state = dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL: begin
                wr_en         = 1'b1;
                refill_sel    = 1'b1;
                refill_update = 1'b1;
                data_from_ret = 1'b1;
                next_state    = dcache_pkg::WAIT_WB;
            end
            dcache_pkg::WAIT_WB: begin
                data_from_ret = 1'b1;
                if (wb_done) begin
                    rready     = !is_write;
                    wready     = is_write;
                    wb_clear   = 1'b1;
                    next_state = dcache_pkg::IDLE;
                end
            end
            default: next_state = dcache_pkg::IDLE;
        endcase
    end

endmodule

//--- source/dcache_replace.sv
`timescale 1ns/1ns

module dcache_replace (
    input  logic               clk,
    input  logic               rstn,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::way_t   hit_way,
    input  logic               hit_update,
    input  logic               refill_update,
    input  logic               is_write,
    output dcache_pkg::way_t   victim_way,
    output logic               victim_dirty
);

    logic [dcache_pkg::SET_NUM-1:0] mru;         // most recently used way per set
    logic [dcache_pkg::SET_NUM-1:0] dirty [2];

    //////////////////////////////
    // lru and dirty update
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru      <= '1;                      // way 0 is the first victim
            dirty[0] <= '0;
            dirty[1] <= '0;
        end else if (hit_update) begin
            mru[index] <= hit_way;
            if (is_write)
                dirty[hit_way][index] <= 1'b1;
        end else if (refill_update) begin
            mru[index]               <= victim_way;
            dirty[victim_way][index] <= is_write;  // fresh line is dirty only if written
        end
    end

    // with two ways the victim is simply the other one
    assign victim_way   = ~mru[index];
    assign victim_dirty = dirty[victim_way][index];

endmodule

//--- source/dcache_lookup.sv
`timescale 1ns/1ns

module dcache_lookup (
    input  logic                   clk,
    input  logic                   rstn,
    input  dcache_pkg::addr_t      addr,
    input  dcache_pkg::word_t      wdata,
    input  dcache_pkg::strb_t      wstrb,
    input  logic                   req_load,
    input  logic                   data_from_ret,   // select return buffer over the ways
    input  dcache_pkg::line_t      rd_line0,
    input  dcache_pkg::line_t      rd_line1,
    input  dcache_pkg::tagv_t      rd_tagv0,
    input  dcache_pkg::tagv_t      rd_tagv1,
    input  dcache_pkg::line_t      ret_line,
    output dcache_pkg::cpu_req_t   cur_req,
    output logic                   hit,
    output dcache_pkg::way_t       hit_way,
    output dcache_pkg::word_t      rdata,
    output dcache_pkg::line_strb_t hit_strb,
    output dcache_pkg::line_t      merge_line
);

    dcache_pkg::tag_t  req_tag;
    dcache_pkg::woff_t req_woff;
    logic              hit0;
    logic              hit1;
    dcache_pkg::line_t sel_line;
    dcache_pkg::line_t wr_word_line;     // write word moved to its slot
    dcache_pkg::line_t wr_bit_mask;

    //////////////////////////////
    // request buffer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn)
            cur_req <= '0;
        else if (req_load)
            cur_req <= '{addr: addr, wdata: wdata, wstrb: wstrb};
    end

    assign req_tag  = cur_req.addr[31 -: dcache_pkg::TAG_WIDTH];
    assign req_woff = cur_req.addr[2 +: dcache_pkg::WORD_OFFSET_WIDTH];

    //////////////////////////////
    // tag compare
    //////////////////////////////
    assign hit0    = rd_tagv0.valid && (rd_tagv0.tag == req_tag);
    assign hit1    = rd_tagv1.valid && (rd_tagv1.tag == req_tag);
    assign hit     = hit0 | hit1;
    assign hit_way = hit1;               // only meaningful with hit

    // read word from the hit way or from the refilled line
    always_comb begin
        if (data_from_ret)
            sel_line = ret_line;
        else
            sel_line = hit_way ? rd_line1 : rd_line0;
    end
    assign rdata = sel_line[{req_woff, 5'b0} +: 32];

    //////////////////////////////
    // write data merge
    //////////////////////////////
    assign hit_strb     = dcache_pkg::line_strb_t'(cur_req.wstrb) << {req_woff, 2'b00};
    assign wr_word_line = dcache_pkg::line_t'(cur_req.wdata) << {req_woff, 5'b0};

    always_comb begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++)
            wr_bit_mask[b*8 +: 8] = {8{hit_strb[b]}};
    end

    // hit path writes only the masked bytes and refill writes the whole line
    assign merge_line = data_from_ret ? ((ret_line & ~wr_bit_mask) | (wr_word_line & wr_bit_mask))
                                      : wr_word_line;

endmodule

//--- source/dcache_storage.sv
`timescale 1ns/1ns

module dcache_storage (
    input  logic                   clk,
    input  logic                   rstn,
    input  dcache_pkg::index_t     rd_index,
    input  dcache_pkg::index_t     wr_index,
    input  dcache_pkg::way_t       wr_way,
    input  dcache_pkg::line_strb_t wr_strb,   // zero means no data write
    input  dcache_pkg::line_t      wr_line,
    input  dcache_pkg::tag_t       wr_tag,
    input  logic                   tag_we,
    output dcache_pkg::line_t      rd_line0,
    output dcache_pkg::line_t      rd_line1,
    output dcache_pkg::tagv_t      rd_tagv0,
    output dcache_pkg::tagv_t      rd_tagv1
);

    dcache_pkg::line_t             data_mem [2][dcache_pkg::SET_NUM];
    dcache_pkg::tag_t              tag_mem  [2][dcache_pkg::SET_NUM];
    logic [dcache_pkg::SET_NUM-1:0] valid   [2];
    dcache_pkg::line_t             rd_line  [2];
    dcache_pkg::tagv_t             rd_tagv  [2];

    // valid bits per way, set along with the tag
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid[0] <= '0;
            valid[1] <= '0;
        end else if (tag_we) begin
            valid[wr_way][wr_index] <= 1'b1;
        end
    end

    // byte enabled write on the selected way
    always_ff @(posedge clk) begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            if (wr_strb[b])
                data_mem[wr_way][wr_index][b*8 +: 8] <= wr_line[b*8 +: 8];
        end
        if (tag_we)
            tag_mem[wr_way][wr_index] <= wr_tag;
    end

    // both ways are read every cycle and return old data on a same-index write
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            rd_line[w] <= data_mem[w][rd_index];
            rd_tagv[w] <= '{valid: valid[w][rd_index], tag: tag_mem[w][rd_index]};
        end
    end

    assign rd_line0 = rd_line[0];
    assign rd_line1 = rd_line[1];
    assign rd_tagv0 = rd_tagv[0];
    assign rd_tagv1 = rd_tagv[1];

endmodule

//--- source/dcache_pkg.sv
package dcache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam int INDEX_WIDTH       = 4;
    localparam int WORD_OFFSET_WIDTH = 2;
    localparam int BYTE_OFFSET_WIDTH = WORD_OFFSET_WIDTH + 2;        // word offset plus byte
    localparam int TAG_WIDTH         = 32 - BYTE_OFFSET_WIDTH - INDEX_WIDTH;
    localparam int SET_NUM           = 1 << INDEX_WIDTH;
    localparam int WORD_NUM          = 1 << WORD_OFFSET_WIDTH;        // also the burst length
    localparam int LINE_BYTES        = WORD_NUM * 4;
    localparam int LINE_BITS         = LINE_BYTES * 8;

    //////////////////////////////
    // vector types
    //////////////////////////////
    typedef logic [31:0]                  addr_t;
    typedef logic [31:0]                  word_t;
    typedef logic [3:0]                   strb_t;
    typedef logic [TAG_WIDTH-1:0]         tag_t;
    typedef logic [INDEX_WIDTH-1:0]       index_t;
    typedef logic [WORD_OFFSET_WIDTH-1:0] woff_t;
    typedef logic [LINE_BITS-1:0]         line_t;
    typedef logic [LINE_BYTES-1:0]        line_strb_t;
    typedef logic                         way_t;

    // buffered pipeline request that is a write when any mask bit is set
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    //////////////////////////////
    // state machines
    //////////////////////////////
    typedef enum logic [2:0] {
        IDLE, LOOKUP, MISS, REFILL, WAIT_WB
    } ctrl_state_t;

    typedef enum logic [1:0] {
        WB_IDLE, WB_DATA, WB_RESP, WB_DONE
    } wb_state_t;

endpackage
